// File: project.f
fifo_pkg.sv
fifo_ram_2p.sv
fifo_level_ctrl.sv
fifo_asym_conv.sv
fifo_sync_top.sv
tb_clock_gen.sv
tb_fifo_checker.sv
tb_fifo_sync.sv

// File: run_sim.sh
#!/bin/sh
# builds the FIFO testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_fifo_sync -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_fifo_sync)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
   exit 0
fi
exit 1

// File: tb_fifo_sync.sv
////////////////////
// testbench top, LFSR driven write/read phases on the FIFO
// comparisons live in the checker module
////////////////////
`default_nettype none

module tb_fifo_sync;

   logic              clk;
   logic              rst;
   logic              w_en;
   logic              r_en;
   fifo_pkg::w_word_t w_data;
   logic              w_full;
   logic              r_empty;
   fifo_pkg::r_word_t r_data;
   fifo_pkg::level_t  level;
   int                err_cnt;
   int                chk_cnt;
   int                timeouts;
   int                err_mark;
   int                wp;
   int                rp;
   logic [15:0]       lfsr_state;

   tb_clock_gen clkgen0 (.clk_o(clk), .rst_o(rst));

   fifo_sync_top UUT (
      .clk_i(clk), .rst_i(rst), .w_en_i(w_en), .w_data_i(w_data), .w_full_o(w_full),
      .r_en_i(r_en), .r_data_o(r_data), .r_empty_o(r_empty), .level_o(level)
   );

   tb_fifo_checker chk0 (
      .clk_i(clk), .rst_i(rst), .w_en_i(w_en), .w_data_i(w_data), .r_en_i(r_en),
      .w_full_i(w_full), .r_empty_i(r_empty), .r_data_i(r_data), .level_i(level),
      .err_cnt_o(err_cnt), .chk_cnt_o(chk_cnt)
   );

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0]) n = n ^ 16'hb400;  // taps 16 14 13 11
      return n;
   endfunction

   // one LFSR step per bit taken
   function automatic int take_bits(input int count);
      int val;
      val = 0;
      for (int i = 0; i < count; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         val = (val << 1) | int'(lfsr_state[0]);
      end
      return val;
   endfunction

   task automatic drive_word(input logic we, input logic re, input fifo_pkg::w_word_t data);
      @(negedge clk);
      w_en   = we;
      r_en   = re;
      w_data = data;
   endtask

   // odds out of 16
   task automatic drive_random(input int w_odds, input int r_odds);
      logic              we;
      logic              re;
      fifo_pkg::w_word_t data;
      we   = take_bits(4) < w_odds;
      re   = take_bits(4) < r_odds;
      data = take_bits(32);
      drive_word(we, re, data);
   endtask

   task automatic run_until_flag(input int w_odds, input int r_odds, input logic want_full);
      int n;
      n = 0;
      do begin
         drive_random(w_odds, r_odds);
         n++;
      end while (!(want_full ? w_full : r_empty) && n < 400);
      if (!(want_full ? w_full : r_empty)) begin
         $display("timeout: the %s flag never rose", want_full ? "full" : "empty");
         timeouts++;
      end
   endtask

   task automatic end_test(input string name);
      @(posedge clk);
      $display("test %s finished with %0d errors", name, err_cnt - err_mark);
      err_mark = err_cnt;
   endtask

   initial begin
      int n;
      lfsr_state = 16'd47534;
      w_en       = 1'b0;
      r_en       = 1'b0;
      w_data     = '0;
      timeouts   = 0;
      err_mark   = 0;
      n          = 0;
      do begin
         @(negedge clk);
         n++;
      end while (rst && n < 20);
      if (rst) begin
         $display("timeout: reset was never released");
         timeouts++;
      end
      if (timeouts == 0) begin
         repeat (4) drive_word(1'b0, 1'b1, '0);  // reads while empty
         end_test("reset_state");
         run_until_flag(15, 2, 1'b1);
         end_test("fill_to_full");
      end
      if (timeouts == 0) begin
         for (int i = 0; i < 8; i++) drive_word(1'b1, 1'b0, 32'hdead_0000 | 32'(i));
         end_test("full_refuse");
         run_until_flag(0, 16, 1'b0);
         end_test("drain_to_empty");
      end
      if (timeouts == 0) begin
         repeat (6) drive_word(1'b0, 1'b1, '0);
         end_test("empty_refuse");
         repeat (600) drive_random(3, 12);  // level roughly steady
         end_test("width_order");
         for (int b = 0; b < 16; b++) begin
            wp = 1 + take_bits(3);
            rp = 8 + take_bits(3);
            repeat (250) drive_random(wp, rp);
         end
         repeat (3) drive_word(1'b0, 1'b0, '0);
         end_test("random_mixed");
      end
      $display("checks %0d, errors %0d, timeouts %0d", chk_cnt, err_cnt, timeouts);
      if (err_cnt == 0 && timeouts == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb_fifo_checker.sv
////////////////////
// byte queue model of the FIFO, compares the DUT outputs
// on every falling edge and counts the mismatches
////////////////////
`default_nettype none

module tb_fifo_checker (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              w_en_i,
   input  fifo_pkg::w_word_t w_data_i,
   input  logic              r_en_i,
   input  logic              w_full_i,
   input  logic              r_empty_i,
   input  fifo_pkg::r_word_t r_data_i,
   input  fifo_pkg::level_t  level_i,
   output int                err_cnt_o,
   output int                chk_cnt_o
);

   fifo_pkg::r_word_t byte_q [$];        // bytes in the order they must come out
   fifo_pkg::r_word_t exp_data   = '0;
   fifo_pkg::r_word_t pend_byte  = '0;   // popped, lands one edge later
   logic              pend_valid = 1'b0;
   logic              in_reset   = 1'b1;
   int                mlevel     = 0;
   int                err_cnt    = 0;
   int                chk_cnt    = 0;

   assign err_cnt_o = err_cnt;
   assign chk_cnt_o = chk_cnt;

   task automatic check_equal(input string what, input int got, input int expected);
      chk_cnt++;
      if (got != expected) begin
         err_cnt++;
         $display("Error at time %0t: %s is %0d, expected %0d", $time, what, got, expected);
      end
   endtask

   // inputs are stable here since the testbench drives them on the falling edge
   always @(posedge clk_i) begin
      logic wacc;
      logic racc;
      in_reset = rst_i;
      if (rst_i) begin
         byte_q.delete();
         mlevel     = 0;
         exp_data   = '0;
         pend_valid = 1'b0;
      end else begin
         wacc = w_en_i && !(mlevel > fifo_pkg::FIFO_SIZE - fifo_pkg::W_INCR);
         racc = r_en_i && !(mlevel < fifo_pkg::R_INCR);
         if (pend_valid) exp_data = pend_byte;
         pend_valid = racc;
         if (racc) pend_byte = byte_q.pop_front();
         if (wacc) begin
            for (int k = 0; k < fifo_pkg::RATIO; k++) begin
               byte_q.push_back(w_data_i[k*fifo_pkg::R_DATA_W +: fifo_pkg::R_DATA_W]);
            end
         end
         mlevel = mlevel + (wacc ? fifo_pkg::W_INCR : 0) - (racc ? fifo_pkg::R_INCR : 0);
      end
   end

   // all DUT outputs are registered, so mid-cycle is a quiet point
   always @(negedge clk_i) begin
      if (!in_reset) begin
         check_equal("level_o", int'(level_i), mlevel);
         check_equal("r_empty_o", int'(r_empty_i), int'(mlevel < fifo_pkg::R_INCR));
         check_equal("w_full_o", int'(w_full_i),
                     int'(mlevel > fifo_pkg::FIFO_SIZE - fifo_pkg::W_INCR));
         check_equal("r_data_o", int'(r_data_i), int'(exp_data));
         if (int'(level_i) > fifo_pkg::FIFO_SIZE) begin
            err_cnt++;
            $display("Error at time %0t: level_o is %0d, above the capacity", $time, level_i);
         end
      end
   end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
////////////////////
// testbench clock of 40 time units per period
// reset held high over the first 3 rising edges
////////////////////
`default_nettype none

module tb_clock_gen (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever #20 clk_o = ~clk_o;
   end

   initial begin
      rst_o = 1'b1;
      repeat (3) @(posedge clk_o);
      rst_o <= 1'b0;  // DUT still sees it high on this edge
   end

endmodule

`default_nettype wire

// File: fifo_sync_top.sv
////////////////////
// synchronous FIFO, 32-bit write and 8-bit read
// write and read are strobes qualified by full and empty
////////////////////
`default_nettype none

module fifo_sync_top (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              w_en_i,
   input  fifo_pkg::w_word_t w_data_i,
   output logic              w_full_o,
   input  logic              r_en_i,
   output fifo_pkg::r_word_t r_data_o,
   output logic              r_empty_o,
   output fifo_pkg::level_t  level_o
);

   logic              w_acc;
   logic              r_acc;
   fifo_pkg::w_addr_t w_addr;
   fifo_pkg::r_addr_t r_addr;
   fifo_pkg::ram_wr_t ram_wr;
   fifo_pkg::ram_rd_t ram_rd;
   fifo_pkg::row_t    ram_rdata;

   fifo_level_ctrl ctrl0 (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .w_en_i   (w_en_i),
      .r_en_i   (r_en_i),
      .w_acc_o  (w_acc),
      .r_acc_o  (r_acc),
      .w_addr_o (w_addr),
      .r_addr_o (r_addr),
      .level_o  (level_o),
      .w_full_o (w_full_o),
      .r_empty_o(r_empty_o)
   );

   fifo_asym_conv conv0 (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .w_acc_i    (w_acc),
      .w_addr_i   (w_addr),
      .w_data_i   (w_data_i),
      .r_acc_i    (r_acc),
      .r_addr_i   (r_addr),
      .r_data_o   (r_data_o),
      .ram_wr_o   (ram_wr),
      .ram_rd_o   (ram_rd),
      .ram_rdata_i(ram_rdata)
   );

   fifo_ram_2p ram0 (
      .clk_i  (clk_i),
      .wr_i   (ram_wr),
      .rd_i   (ram_rd),
      .rdata_o(ram_rdata)
   );

endmodule

`default_nettype wire

// File: fifo_asym_conv.sv
////////////////////
// maps write and read address spaces onto wide RAM rows
// lane 0 is the least significant part of a row
////////////////////
`default_nettype none

module fifo_asym_conv (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              w_acc_i,
   input  fifo_pkg::w_addr_t w_addr_i,
   input  fifo_pkg::w_word_t w_data_i,
   input  logic              r_acc_i,
   input  fifo_pkg::r_addr_t r_addr_i,
   output fifo_pkg::r_word_t r_data_o,
   output fifo_pkg::ram_wr_t ram_wr_o,
   output fifo_pkg::ram_rd_t ram_rd_o,
   input  fifo_pkg::row_t    ram_rdata_i
);

   logic rd_pend_q;  // RAM read in flight

   always_ff @(posedge clk_i) begin
      if (rst_i) rd_pend_q <= 1'b0;
      else       rd_pend_q <= r_acc_i;
   end

   if (fifo_pkg::W_DATA_W > fifo_pkg::R_DATA_W) begin : g_wide_wr
      logic [fifo_pkg::LANE_W-1:0] lane_q;

      always_comb begin
         ram_wr_o.en   = w_acc_i;
         ram_wr_o.addr = w_addr_i;  // one wide word per row
         ram_wr_o.data = w_data_i;
         ram_rd_o.en   = r_acc_i;
         ram_rd_o.addr = r_addr_i[fifo_pkg::ADDR_W-1:fifo_pkg::LANE_W];
      end

      // lane waits alongside the RAM read
      always_ff @(posedge clk_i) begin
         if (r_acc_i) lane_q <= r_addr_i[fifo_pkg::LANE_W-1:0];
      end

      always_ff @(posedge clk_i) begin
         if (rst_i) begin
            r_data_o <= '0;
         end else if (rd_pend_q) begin
            r_data_o <= ram_rdata_i[lane_q*fifo_pkg::R_DATA_W +: fifo_pkg::R_DATA_W];
         end
      end

      // back-to-back reads take neighbouring lanes
      a_lane_step : assert property (@(posedge clk_i) disable iff (rst_i)
         rd_pend_q && $past(rd_pend_q) |->
            int'(lane_q) == (int'($past(lane_q)) + 1) % fifo_pkg::RATIO);
   end else begin : g_narrow_wr
      logic [fifo_pkg::LANE_W-1:0] w_lane;
      fifo_pkg::row_t              wbuf_q;     // lanes collected so far
      fifo_pkg::row_t              row_merged;

      assign w_lane = w_addr_i[fifo_pkg::LANE_W-1:0];

      always_ff @(posedge clk_i) begin
         if (w_acc_i) wbuf_q[w_lane*fifo_pkg::W_DATA_W +: fifo_pkg::W_DATA_W] <= w_data_i;
      end

      // last lane goes to the RAM together with the buffered ones
      always_comb begin
         row_merged = wbuf_q;
         row_merged[w_lane*fifo_pkg::W_DATA_W +: fifo_pkg::W_DATA_W] = w_data_i;
      end

      always_comb begin
         ram_wr_o.en   = w_acc_i && (w_lane == '1);
         ram_wr_o.addr = w_addr_i[fifo_pkg::ADDR_W-1:fifo_pkg::LANE_W];
         ram_wr_o.data = row_merged;
         ram_rd_o.en   = r_acc_i;
         ram_rd_o.addr = r_addr_i;
      end

      always_ff @(posedge clk_i) begin
         if (rst_i)          r_data_o <= '0;
         else if (rd_pend_q) r_data_o <= ram_rdata_i;
      end
   end

endmodule

`default_nettype wire

// File: fifo_level_ctrl.sv
////////////////////
// FIFO controller with request gating, address counters,
// registered level and empty/full flags
////////////////////
`default_nettype none

module fifo_level_ctrl (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              w_en_i,
   input  logic              r_en_i,
   output logic              w_acc_o,
   output logic              r_acc_o,
   output fifo_pkg::w_addr_t w_addr_o,
   output fifo_pkg::r_addr_t r_addr_o,
   output fifo_pkg::level_t  level_o,
   output logic              w_full_o,
   output logic              r_empty_o
);

   fifo_pkg::level_t level_nxt;
   logic             empty_nxt;
   logic             full_nxt;

   // refused requests simply drop out here
   assign w_acc_o = w_en_i & ~w_full_o;
   assign r_acc_o = r_en_i & ~r_empty_o;

   // address counters wrap on their own width
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         w_addr_o <= '0;
         r_addr_o <= '0;
      end else begin
         if (w_acc_o) w_addr_o <= w_addr_o + fifo_pkg::w_addr_t'(1);
         if (r_acc_o) r_addr_o <= r_addr_o + fifo_pkg::r_addr_t'(1);
      end
   end

   always_comb begin
      level_nxt = level_o;
      case ({w_acc_o, r_acc_o})
         2'b10: level_nxt = level_o + fifo_pkg::level_t'(fifo_pkg::W_INCR);  // write only
         2'b01: level_nxt = level_o - fifo_pkg::level_t'(fifo_pkg::R_INCR);  // read only
         2'b11: level_nxt = level_o + fifo_pkg::level_t'(fifo_pkg::W_INCR)
                            - fifo_pkg::level_t'(fifo_pkg::R_INCR);
         default: level_nxt = level_o;
      endcase
   end

   // flags follow the next level so they line up with level_o
   assign empty_nxt = level_nxt < fifo_pkg::level_t'(fifo_pkg::R_INCR);
   assign full_nxt  = level_nxt > fifo_pkg::level_t'(fifo_pkg::FIFO_SIZE - fifo_pkg::W_INCR);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         level_o   <= '0;
         r_empty_o <= 1'b1;
         w_full_o  <= 1'b0;
      end else begin
         level_o   <= level_nxt;
         r_empty_o <= empty_nxt;
         w_full_o  <= full_nxt;
      end
   end

   // level stays within capacity
   a_level_max : assert property (@(posedge clk_i) disable iff (rst_i)
      level_o <= fifo_pkg::level_t'(fifo_pkg::FIFO_SIZE));

   // a read only goes through with at least one narrow word stored
   a_read_has_data : assert property (@(posedge clk_i) disable iff (rst_i)
      r_acc_o |-> level_o >= fifo_pkg::level_t'(fifo_pkg::R_INCR));

   a_flags_match : assert property (@(posedge clk_i) disable iff (rst_i)
      (r_empty_o == (level_o < fifo_pkg::level_t'(fifo_pkg::R_INCR))) &&
      (w_full_o == (level_o >
         fifo_pkg::level_t'(fifo_pkg::FIFO_SIZE - fifo_pkg::W_INCR))));

endmodule

`default_nettype wire

// File: fifo_ram_2p.sv
////////////////////
// simple dual-port RAM, one wide row per entry
// read data appears the cycle after the read enable
////////////////////
`default_nettype none

module fifo_ram_2p (
   input  logic              clk_i,
   input  fifo_pkg::ram_wr_t wr_i,
   input  fifo_pkg::ram_rd_t rd_i,
   output fifo_pkg::row_t    rdata_o
);

   fifo_pkg::row_t mem [2**fifo_pkg::ROW_ADDR_W];

   always_ff @(posedge clk_i) begin
      if (wr_i.en) begin
         mem[wr_i.addr] <= wr_i.data;
      end
   end

   // registered read port
   always_ff @(posedge clk_i) begin
      if (rd_i.en) begin
         rdata_o <= mem[rd_i.addr];
      end
   end

endmodule

`default_nettype wire

// File: fifo_pkg.sv
////////////////////
// widths, depth and shared types of the asymmetric sync FIFO
// referenced by scoped names from every design file
////////////////////
`default_nettype none

package fifo_pkg;

   localparam int W_DATA_W = 32;  // write port
   localparam int R_DATA_W = 8;   // read port
   localparam int ADDR_W   = 6;   // in narrow words

   localparam int MAXDATA_W = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int MINDATA_W = (W_DATA_W > R_DATA_W) ? R_DATA_W : W_DATA_W;
   localparam int RATIO     = MAXDATA_W / MINDATA_W;
   localparam int LANE_W    = $clog2(RATIO);

   // the wide side addresses whole rows
   localparam int W_ADDR_W   = (W_DATA_W == MAXDATA_W) ? ADDR_W - LANE_W : ADDR_W;
   localparam int R_ADDR_W   = (R_DATA_W == MAXDATA_W) ? ADDR_W - LANE_W : ADDR_W;
   localparam int ROW_ADDR_W = ADDR_W - LANE_W;

   // level steps, counted in narrow words
   localparam int W_INCR    = (W_DATA_W > R_DATA_W) ? RATIO : 1;
   localparam int R_INCR    = (R_DATA_W > W_DATA_W) ? RATIO : 1;
   localparam int FIFO_SIZE = 2 ** ADDR_W;

   typedef logic [W_DATA_W-1:0]   w_word_t;
   typedef logic [R_DATA_W-1:0]   r_word_t;
   typedef logic [MAXDATA_W-1:0]  row_t;
   typedef logic [W_ADDR_W-1:0]   w_addr_t;
   typedef logic [R_ADDR_W-1:0]   r_addr_t;
   typedef logic [ROW_ADDR_W-1:0] row_addr_t;
   typedef logic [ADDR_W:0]       level_t;  // one extra bit to hold FIFO_SIZE

   typedef struct packed {
      logic      en;
      row_addr_t addr;
      row_t      data;
   } ram_wr_t;

   typedef struct packed {
      logic      en;
      row_addr_t addr;
   } ram_rd_t;

endpackage

`default_nettype wire
